// File: Makefile
TOP = aluDatapathTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module $(TOP)

# the run passes only with the pass line present and no fail line
sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP) -o simv
	./obj_dir/simv +verilator+error+limit+1000 > sim.log 2>&1; cat sim.log
	grep -q "No errors" sim.log
	! grep -q "Errors found" sim.log

clean:
	rm -rf obj_dir sim.log

// File: all.f
design/aluPkg.sv
design/claAdder.sv
design/barrelShifter.sv
design/alu.sv
design/registerFile.sv
design/aluDatapath.sv
verif/aluDatapathChecker.sv
verif/aluDatapathTb.sv

// File: design/alu.sv
//****************************************
// combinational alu, nzvc flags
// carry and overflow only valid for add and sub
//****************************************
`timescale 1ns/1ps

module alu (
	input  aluPkg::aluOpT    op,
	input  aluPkg::wordT     operandA,
	input  aluPkg::wordT     operandB,
	output aluPkg::wordT     result,
	output aluPkg::aluFlagsT flags
);
	// adder inputs and outputs
	logic         isSub;
	logic         isArith;
	aluPkg::wordT adderB;
	aluPkg::wordT sum;
	logic         adderCout;
	logic         adderOverflow;
	// shifter output
	aluPkg::wordT shifted;

	// subtract is a + ~b + 1
	assign isSub   = (op == aluPkg::opSub);
	assign isArith = (op == aluPkg::opAdd) || isSub;
	assign adderB  = isSub ? ~operandB : operandB;

	// group p/g left open, only the carries matter here
	cla32 u_cla32 (
		.inA      (operandA),
		.inB      (adderB),
		.cin      (isSub),
		.sum      (sum),
		.cout     (adderCout),
		.overflow (adderOverflow),
		.pGroup   (),
		.gGroup   ()
	);

	// shift amount is the low five bits of b
	barrelShifter u_shifter (
		.value      (operandA),
		.shamt      (operandB[4:0]),
		.shiftRight (op == aluPkg::opShr),
		.shifted    (shifted)
	);

	// output select
	always_comb begin
		case (op)
			aluPkg::opAdd,
			aluPkg::opSub: begin
				result = sum;
			end
			aluPkg::opAnd: begin
				result = operandA & operandB;
			end
			aluPkg::opOr: begin
				result = operandA | operandB;
			end
			aluPkg::opXor: begin
				result = operandA ^ operandB;
			end
			aluPkg::opPassB: begin
				result = operandB;
			end
			aluPkg::opShl,
			aluPkg::opShr: begin
				result = shifted;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// n and z from the result for every op
	assign flags.negative = result[31];
	assign flags.zero     = (result == '0);
	// carry set on sub means no borrow
	assign flags.carry    = isArith & adderCout;
	assign flags.overflow = isArith & adderOverflow;
endmodule

// File: design/aluDatapath.sv
//****************************************
// execute stage top, one command per cycle
// load port wins over write-back in the same cycle
//****************************************
`timescale 1ns/1ps

module aluDatapath (
	input  logic             clk,
	input  logic             reset,
	input  aluPkg::aluCmdT   cmd,
	input  logic             loadEnable,
	input  aluPkg::regAddrT  loadAddr,
	input  aluPkg::wordT     loadData,
	output aluPkg::wordT     result,
	output aluPkg::aluFlagsT flags
);
	// register file read data
	aluPkg::wordT     readDataA;
	aluPkg::wordT     readDataB;
	// b side after the immediate mux
	aluPkg::wordT     operandB;
	aluPkg::aluFlagsT aluFlags;
	// arbitrated write port
	logic             regWriteEnable;
	aluPkg::regAddrT  regWriteAddr;
	aluPkg::wordT     regWriteData;

	// load port first, then command write-back
	assign regWriteEnable = loadEnable | cmd.writeEnable;
	assign regWriteAddr   = loadEnable ? loadAddr : cmd.dest;
	assign regWriteData   = loadEnable ? loadData : result;

	registerFile u_regFile (
		.clk         (clk),
		.reset       (reset),
		.readAddrA   (cmd.srcA),
		.readAddrB   (cmd.srcB),
		.readDataA   (readDataA),
		.readDataB   (readDataB),
		.writeEnable (regWriteEnable),
		.writeAddr   (regWriteAddr),
		.writeData   (regWriteData)
	);

	// immediate replaces read port b
	assign operandB = cmd.useImm ? cmd.imm : readDataB;

	alu u_alu (
		.op       (cmd.op),
		.operandA (readDataA),
		.operandB (operandB),
		.result   (result),
		.flags    (aluFlags)
	);

	// flag register, updated only on flag-enabled commands
	always_ff @(posedge clk) begin
		if (reset) begin
			flags <= '0;
		end else if (cmd.flagEnable) begin
			flags <= aluFlags;
		end
	end
endmodule

// File: design/aluPkg.sv
//****************************************
// shared types for the execute stage datapath
// register 31 is the hardwired zero register
//****************************************
package aluPkg;

	// data word carried through the register file and the alu
	typedef logic [31:0] wordT;

	// register index into the 32-entry file
	typedef logic [4:0] regAddrT;

	// shift amount, low five bits of operand b
	typedef logic [4:0] shamtT;

	// number of registers in the file
	localparam int numRegs = 32;

	// index that always reads zero
	localparam int zeroReg = 31;

	// alu operation codes
	typedef enum logic [2:0] {
		opAdd   = 3'd0,
		opSub   = 3'd1,
		opAnd   = 3'd2,
		opOr    = 3'd3,
		opXor   = 3'd4,
		opPassB = 3'd5,
		opShl   = 3'd6,
		opShr   = 3'd7
	} aluOpT;

	// condition flags, nzvc order
	typedef struct packed {
		logic negative;
		logic zero;
		logic overflow;
		logic carry;
	} aluFlagsT;

	// one command per cycle, 53 bits
	typedef struct packed {
		aluOpT   op;
		regAddrT srcA;
		regAddrT srcB;
		regAddrT dest;
		logic    writeEnable;
		logic    flagEnable;
		logic    useImm;
		// zero-extended immediate
		wordT    imm;
	} aluCmdT;

endpackage

// File: design/barrelShifter.sv
//****************************************
// logical shifter, zero fill in both directions
// right shift reuses the left stages on reversed bits
//****************************************
`timescale 1ns/1ps

module barrelShifter (
	input  aluPkg::wordT  value,
	input  aluPkg::shamtT shamt,
	input  logic          shiftRight,
	output aluPkg::wordT  shifted
);
	// stage[0] is the input, stage[5] the fully shifted word
	aluPkg::wordT stage [6];
	aluPkg::wordT valueRev;
	aluPkg::wordT stageRev;

	// bit reversal of the input for right shifts
	always_comb begin
		for (int i = 0; i < 32; i++) begin
			valueRev[i] = value[31-i];
		end
	end

	assign stage[0] = shiftRight ? valueRev : value;

	// stage k shifts left by 2**k when shamt bit k is set
	for (genvar k = 0; k < 5; k++) begin : gStage
		assign stage[k+1] = shamt[k] ? (stage[k] << (1 << k)) : stage[k];
	end

	// undo the reversal on the way out
	always_comb begin
		for (int i = 0; i < 32; i++) begin
			stageRev[i] = stage[5][31-i];
		end
	end

	assign shifted = shiftRight ? stageRev : stage[5];
endmodule

// File: design/claAdder.sv
//****************************************
// carry look-ahead adder, 4/16/32-bit levels
// widths are fixed by the block structure
//****************************************
`timescale 1ns/1ps

// 4-bit block with full look-ahead carries
module cla4 (
	input  logic [3:0] inA,
	input  logic [3:0] inB,
	input  logic       cin,
	output logic [3:0] sum,
	output logic       cout,
	output logic       pGroup,
	output logic       gGroup
);
	// bit propagate, generate and carry into each bit
	logic [3:0] p;
	logic [3:0] g;
	logic [3:0] c;

	assign p = inA ^ inB;
	assign g = inA & inB;

	// look-ahead carries, all from cin directly
	assign c[0] = cin;
	assign c[1] = g[0] | (p[0] & cin);
	assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
	assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
		| (p[2] & p[1] & p[0] & cin);

	// group signals for the next level up
	assign pGroup = &p;
	assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]);

	assign cout = gGroup | (pGroup & cin);
	assign sum  = p ^ c;
endmodule

// four 4-bit blocks chained by carry
module cla16 (
	input  logic [15:0] inA,
	input  logic [15:0] inB,
	input  logic        cin,
	output logic [15:0] sum,
	output logic        cout,
	output logic        pGroup,
	output logic        gGroup
);
	// per-block group signals and carries between blocks
	logic [3:0] p;
	logic [3:0] g;
	logic [4:0] c;

	assign c[0] = cin;

	for (genvar k = 0; k < 4; k++) begin : gBlock
		cla4 u_cla4 (
			.inA    (inA[4*k +: 4]),
			.inB    (inB[4*k +: 4]),
			.cin    (c[k]),
			.sum    (sum[4*k +: 4]),
			.cout   (c[k+1]),
			.pGroup (p[k]),
			.gGroup (g[k])
		);
	end

	assign cout = c[4];

	// combine the four groups into one 16-bit group
	assign pGroup = &p;
	assign gGroup = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1])
		| (p[3] & p[2] & p[1] & g[0]);
endmodule

// two 16-bit halves plus signed overflow
module cla32 (
	input  aluPkg::wordT inA,
	input  aluPkg::wordT inB,
	input  logic         cin,
	output aluPkg::wordT sum,
	output logic         cout,
	output logic         overflow,
	output logic         pGroup,
	output logic         gGroup
);
	logic [1:0] p;
	logic [1:0] g;
	// carry out of the low half
	logic       cMid;
	// carry into bit 31, recovered from the sum bit
	logic       c31;

	cla16 u_claLow (
		.inA    (inA[15:0]),
		.inB    (inB[15:0]),
		.cin    (cin),
		.sum    (sum[15:0]),
		.cout   (cMid),
		.pGroup (p[0]),
		.gGroup (g[0])
	);

	cla16 u_claHigh (
		.inA    (inA[31:16]),
		.inB    (inB[31:16]),
		.cin    (cMid),
		.sum    (sum[31:16]),
		.cout   (cout),
		.pGroup (p[1]),
		.gGroup (g[1])
	);

	assign pGroup = p[1] & p[0];
	assign gGroup = g[1] | (p[1] & g[0]);

	// sum31 = a31 ^ b31 ^ c31, so c31 falls out of the xor
	assign c31      = inA[31] ^ inB[31] ^ sum[31];
	assign overflow = cout ^ c31;
endmodule

// File: design/registerFile.sv
//****************************************
// 32x32 register file, two async reads, one write
// no write-to-read bypass, register 31 reads zero
//****************************************
`timescale 1ns/1ps

module registerFile (
	input  logic            clk,
	input  logic            reset,
	input  aluPkg::regAddrT readAddrA,
	input  aluPkg::regAddrT readAddrB,
	output aluPkg::wordT    readDataA,
	output aluPkg::wordT    readDataB,
	input  logic            writeEnable,
	input  aluPkg::regAddrT writeAddr,
	input  aluPkg::wordT    writeData
);
	// storage, cleared on reset
	aluPkg::wordT regs [aluPkg::numRegs];

	// zero register as an address for compares
	aluPkg::regAddrT zeroAddr;
	logic            writeValid;

	assign zeroAddr = aluPkg::regAddrT'(aluPkg::zeroReg);

	// writes to the zero register are dropped
	assign writeValid = writeEnable && (writeAddr != zeroAddr);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < aluPkg::numRegs; i++) begin
				regs[i] <= '0;
			end
		end else if (writeValid) begin
			regs[writeAddr] <= writeData;
		end
	end

	// combinational reads, old value until the edge
	assign readDataA = (readAddrA == zeroAddr) ? '0 : regs[readAddrA];
	assign readDataB = (readAddrB == zeroAddr) ? '0 : regs[readAddrB];
endmodule

// File: verif/aluDatapathChecker.sv
//****************************************
// concurrent checks on flags and register 31
// failures are also tallied in failTotal
//****************************************
`timescale 1ns/1ps

module aluDatapathChecker (
	input logic             clk,
	input logic             reset,
	input aluPkg::aluCmdT   cmd,
	input aluPkg::wordT     result,
	input aluPkg::aluFlagsT flags
);
	// one tally per assertion
	int failResetFlags = 0;
	int failHold = 0;
	int failZero = 0;
	int failReadA = 0;
	int failReadB = 0;
	int failTotal;
	aluPkg::regAddrT zeroAddr;

	assign zeroAddr  = aluPkg::regAddrT'(aluPkg::zeroReg);
	assign failTotal = failResetFlags + failHold + failZero + failReadA + failReadB;

	// first cycle out of reset sees cleared flags
	resetClearsFlags: assert property (@(posedge clk) $fell(reset) |-> flags == '0)
	else begin
		$error("flags not cleared after reset");
		failResetFlags++;
	end

	// no flag update without flagEnable
	flagsHoldWhenDisabled: assert property (@(posedge clk)
		!reset && !cmd.flagEnable |=> flags == $past(flags))
	else begin
		$error("flags changed while flagEnable was low");
		failHold++;
	end

	// z flag tracks an all-zero result of the enabled command
	zeroFlagMatchesResult: assert property (@(posedge clk)
		!reset && cmd.flagEnable |=> flags.zero == ($past(result) == '0))
	else begin
		$error("zero flag disagrees with the result");
		failZero++;
	end

	// register 31 on both ports, through the alu to the result
	zeroRegReadA: assert property (@(posedge clk)
		!cmd.useImm && cmd.op == aluPkg::opOr && cmd.srcA == zeroAddr
		&& cmd.srcB == zeroAddr |-> result == '0)
	else begin
		$error("or of register 31 with itself gave a nonzero result");
		failReadA++;
	end

	// pass-b of register 31 must give zero
	zeroRegReadB: assert property (@(posedge clk)
		!cmd.useImm && cmd.op == aluPkg::opPassB && cmd.srcB == zeroAddr
		|-> result == '0)
	else begin
		$error("pass-b of register 31 gave a nonzero result");
		failReadB++;
	end
endmodule

// File: verif/aluDatapathTb.sv
//****************************************
// drives on posedge, compares at negedge
// shadow model needs no reads from the DUT
//****************************************
`timescale 1ns/1ps

module aluDatapathTb;
	localparam int randomPairs  = 200;
	localparam int logicRounds  = 20;
	localparam int shiftRounds  = 40;
	// reset, reset reads, corners, random, logic, shift sweep, shift random, ports
	localparam int testCycles   = 16 + 32 + 10 + 4 * randomPairs + 10 * logicRounds
		+ 65 + 4 * shiftRounds + 20;
	localparam int marginCycles = 200;

	logic             clk;
	logic             reset;
	aluPkg::aluCmdT   cmd;
	logic             loadEnable;
	aluPkg::regAddrT  loadAddr;
	aluPkg::wordT     loadData;
	aluPkg::wordT     result;
	aluPkg::aluFlagsT flags;

	// shadow state of the register file and flag register
	aluPkg::wordT     shadow [aluPkg::numRegs];
	aluPkg::aluFlagsT flagModel;
	// write and flag update that land at the next edge
	logic             pendWrite;
	aluPkg::regAddrT  pendAddr;
	aluPkg::wordT     pendData;
	logic             pendFlagEnable;
	aluPkg::aluFlagsT pendFlags;
	aluPkg::wordT     expResult;
	int               errorCount;
	int               checkCount;
	logic [31:0]      lcgState;

	aluDatapath DUT (
		.clk        (clk),
		.reset      (reset),
		.cmd        (cmd),
		.loadEnable (loadEnable),
		.loadAddr   (loadAddr),
		.loadData   (loadData),
		.result     (result),
		.flags      (flags)
	);

	bind aluDatapath aluDatapathChecker u_checker (
		.clk    (clk),
		.reset  (reset),
		.cmd    (cmd),
		.result (result),
		.flags  (flags)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#5 clk = ~clk;
		end
	end

	// watchdog sized from the test length
	initial begin
		#((testCycles + marginCycles) * 10);
		$display("Timeout: the tests did not finish in %0d cycles", testCycles + marginCycles);
		$display("Errors found");
		$finish;
	end

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		// fold high bits down, the low lcg bits cycle quickly
		return lcgState ^ (lcgState >> 16);
	endfunction

	function automatic aluPkg::aluCmdT makeCmd(
		input aluPkg::aluOpT   op,
		input aluPkg::regAddrT srcA,
		input aluPkg::regAddrT srcB,
		input aluPkg::regAddrT dest,
		input logic            writeEnable,
		input logic            flagEnable,
		input logic            useImm,
		input aluPkg::wordT    imm
	);
		aluPkg::aluCmdT c;
		c.op          = op;
		c.srcA        = srcA;
		c.srcB        = srcB;
		c.dest        = dest;
		c.writeEnable = writeEnable;
		c.flagEnable  = flagEnable;
		c.useImm      = useImm;
		c.imm         = imm;
		return c;
	endfunction

	// register 31 always reads zero
	function automatic aluPkg::wordT readShadow(input aluPkg::regAddrT addr);
		return (addr == 5'd31) ? 32'h0 : shadow[addr];
	endfunction

	// expected result and nzvc flags, from the operation rules
	function automatic void computeExpected(
		input  aluPkg::aluOpT    op,
		input  aluPkg::wordT     a,
		input  aluPkg::wordT     b,
		output aluPkg::wordT     res,
		output aluPkg::aluFlagsT fl
	);
		logic [32:0] wide;
		fl = '0;
		case (op)
			aluPkg::opAdd: begin
				wide        = {1'b0, a} + {1'b0, b};
				res         = wide[31:0];
				fl.carry    = wide[32];
				fl.overflow = (a[31] == b[31]) && (res[31] != a[31]);
			end
			aluPkg::opSub: begin
				res         = a - b;
				// carry means no borrow
				fl.carry    = (a >= b);
				fl.overflow = (a[31] != b[31]) && (res[31] != a[31]);
			end
			aluPkg::opAnd: res = a & b;
			aluPkg::opOr: res = a | b;
			aluPkg::opXor: res = a ^ b;
			aluPkg::opPassB: res = b;
			aluPkg::opShl: res = a << b[4:0];
			aluPkg::opShr: res = a >> b[4:0];
			default: res = '0;
		endcase
		fl.negative = res[31];
		fl.zero     = (res == '0);
	endfunction

	// state change of the previous cycle, taken at this edge
	task automatic commitPending();
		if (pendWrite && (pendAddr != 5'd31)) begin
			shadow[pendAddr] = pendData;
		end
		if (pendFlagEnable) begin
			flagModel = pendFlags;
		end
	endtask

	task automatic checkOutputs();
		checkCount++;
		assert (result === expResult) else begin
			$display("[FAIL] %0t: result expected %h, actual %h", $time, expResult, result);
			errorCount++;
		end
		assert (flags === flagModel) else begin
			$display("[FAIL] %0t: flags expected %b, actual %b", $time, flagModel, flags);
			errorCount++;
		end
	endtask

	// one command cycle, optionally with a load
	task automatic issue(
		input aluPkg::aluCmdT  c,
		input logic            ldEn,
		input aluPkg::regAddrT ldAddr,
		input aluPkg::wordT    ldData
	);
		aluPkg::wordT     a;
		aluPkg::wordT     b;
		aluPkg::aluFlagsT expFlags;
		@(posedge clk);
		commitPending();
		cmd        <= c;
		loadEnable <= ldEn;
		loadAddr   <= ldAddr;
		loadData   <= ldData;
		a = readShadow(c.srcA);
		b = c.useImm ? c.imm : readShadow(c.srcB);
		computeExpected(c.op, a, b, expResult, expFlags);
		// load port wins over write-back
		if (ldEn) begin
			pendWrite = 1'b1;
			pendAddr  = ldAddr;
			pendData  = ldData;
		end else begin
			pendWrite = c.writeEnable;
			pendAddr  = c.dest;
			pendData  = expResult;
		end
		pendFlagEnable = c.flagEnable;
		pendFlags      = expFlags;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic regOp(
		input aluPkg::aluOpT   op,
		input aluPkg::regAddrT srcA,
		input aluPkg::regAddrT srcB,
		input aluPkg::regAddrT dest,
		input logic            we,
		input logic            fe
	);
		issue(makeCmd(op, srcA, srcB, dest, we, fe, 1'b0, 32'h0), 1'b0, 5'd0, 32'h0);
	endtask

	task automatic immOp(
		input aluPkg::aluOpT   op,
		input aluPkg::regAddrT srcA,
		input aluPkg::wordT    imm,
		input aluPkg::regAddrT dest,
		input logic            we,
		input logic            fe
	);
		issue(makeCmd(op, srcA, 5'd0, dest, we, fe, 1'b1, imm), 1'b0, 5'd0, 32'h0);
	endtask

	// load with an idle command alongside
	task automatic loadReg(input aluPkg::regAddrT addr, input aluPkg::wordT data);
		issue(makeCmd(aluPkg::opPassB, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 32'h0),
			1'b1, addr, data);
	endtask

	initial begin
		aluPkg::wordT va;
		aluPkg::wordT vb;
		reset          = 1'b1;
		cmd            = '0;
		loadEnable     = 1'b0;
		loadAddr       = '0;
		loadData       = '0;
		lcgState       = 32'd55;
		errorCount     = 0;
		checkCount     = 0;
		flagModel      = '0;
		pendWrite      = 1'b0;
		pendAddr       = '0;
		pendData       = '0;
		pendFlagEnable = 1'b0;
		pendFlags      = '0;
		expResult      = '0;
		for (int i = 0; i < aluPkg::numRegs; i++) begin
			shadow[i] = '0;
		end
		repeat (16) @(posedge clk);
		reset <= 1'b0;

		// every register reads zero after reset
		for (int r = 0; r < aluPkg::numRegs; r++) begin
			regOp(aluPkg::opPassB, 5'd0, aluPkg::regAddrT'(r), 5'd0, 1'b0, 1'b0);
		end

		// add and subtract corners
		loadReg(5'd1, 32'h7FFF_FFFF);
		loadReg(5'd2, 32'h0000_0001);
		loadReg(5'd3, 32'h8000_0000);
		loadReg(5'd0, 32'h0000_0000);
		regOp(aluPkg::opAdd, 5'd1, 5'd2, 5'd0, 1'b0, 1'b1);
		regOp(aluPkg::opSub, 5'd3, 5'd2, 5'd0, 1'b0, 1'b1);
		regOp(aluPkg::opSub, 5'd0, 5'd2, 5'd0, 1'b0, 1'b1);
		regOp(aluPkg::opSub, 5'd1, 5'd1, 5'd0, 1'b0, 1'b1);
		immOp(aluPkg::opAdd, 5'd3, 32'h8000_0000, 5'd0, 1'b0, 1'b1);
		immOp(aluPkg::opAdd, 5'd1, 32'h0000_0001, 5'd0, 1'b0, 1'b1);

		// random pairs, some all-propagate so the carry crosses every group
		for (int n = 0; n < randomPairs; n++) begin
			va = nextRand();
			vb = nextRand();
			if (n % 5 == 0) begin
				vb = ~va;
			end
			loadReg(5'd4, va);
			loadReg(5'd5, vb);
			regOp(aluPkg::opAdd, 5'd4, 5'd5, 5'd0, 1'b0, 1'b1);
			regOp(aluPkg::opSub, 5'd4, 5'd5, 5'd0, 1'b0, 1'b1);
		end

		// logic ops and pass-b, register then immediate operand
		for (int n = 0; n < logicRounds; n++) begin
			va = nextRand();
			vb = nextRand();
			loadReg(5'd6, va);
			loadReg(5'd7, vb);
			regOp(aluPkg::opAnd, 5'd6, 5'd7, 5'd0, 1'b0, 1'b1);
			regOp(aluPkg::opOr, 5'd6, 5'd7, 5'd0, 1'b0, 1'b1);
			regOp(aluPkg::opXor, 5'd6, 5'd7, 5'd0, 1'b0, 1'b1);
			regOp(aluPkg::opPassB, 5'd6, 5'd7, 5'd0, 1'b0, 1'b1);
			immOp(aluPkg::opAnd, 5'd6, vb, 5'd0, 1'b0, 1'b1);
			immOp(aluPkg::opOr, 5'd6, vb, 5'd0, 1'b0, 1'b1);
			immOp(aluPkg::opXor, 5'd6, vb, 5'd0, 1'b0, 1'b1);
			immOp(aluPkg::opPassB, 5'd6, vb, 5'd0, 1'b0, 1'b1);
		end

		// every shift amount, upper immediate bits are noise
		loadReg(5'd8, 32'hA5C3_0F81);
		for (int amt = 0; amt < 32; amt++) begin
			vb      = nextRand();
			vb[4:0] = amt[4:0];
			immOp(aluPkg::opShl, 5'd8, vb, 5'd0, 1'b0, 1'b1);
			immOp(aluPkg::opShr, 5'd8, vb, 5'd0, 1'b0, 1'b1);
		end

		for (int n = 0; n < shiftRounds; n++) begin
			loadReg(5'd9, nextRand());
			loadReg(5'd10, nextRand());
			regOp(aluPkg::opShl, 5'd9, 5'd10, 5'd0, 1'b0, 1'b1);
			regOp(aluPkg::opShr, 5'd9, 5'd10, 5'd0, 1'b0, 1'b1);
		end

		// write-back visible to the next command
		loadReg(5'd11, 32'h0000_0100);
		immOp(aluPkg::opAdd, 5'd11, 32'h0000_0023, 5'd12, 1'b1, 1'b0);
		regOp(aluPkg::opPassB, 5'd0, 5'd12, 5'd0, 1'b0, 1'b0);
		regOp(aluPkg::opAdd, 5'd12, 5'd12, 5'd13, 1'b1, 1'b1);
		regOp(aluPkg::opPassB, 5'd0, 5'd13, 5'd0, 1'b0, 1'b1);
		// load and command write to r14 in one cycle
		issue(makeCmd(aluPkg::opPassB, 5'd0, 5'd0, 5'd14, 1'b1, 1'b0, 1'b1, 32'h1234_5678),
			1'b1, 5'd14, 32'hCAFE_F00D);
		regOp(aluPkg::opPassB, 5'd0, 5'd14, 5'd0, 1'b0, 1'b1);
		// register 31 drops both write paths
		immOp(aluPkg::opPassB, 5'd0, 32'hDEAD_BEEF, 5'd31, 1'b1, 1'b1);
		regOp(aluPkg::opPassB, 5'd0, 5'd31, 5'd0, 1'b0, 1'b1);
		loadReg(5'd31, 32'h1111_1111);
		regOp(aluPkg::opOr, 5'd31, 5'd31, 5'd0, 1'b0, 1'b1);

		// flags hold while flagEnable is low
		regOp(aluPkg::opSub, 5'd1, 5'd1, 5'd0, 1'b0, 1'b1);
		immOp(aluPkg::opPassB, 5'd0, 32'h8000_0000, 5'd0, 1'b0, 1'b0);
		regOp(aluPkg::opAdd, 5'd1, 5'd2, 5'd0, 1'b0, 1'b0);
		immOp(aluPkg::opShl, 5'd2, 32'd31, 5'd15, 1'b1, 1'b0);
		regOp(aluPkg::opPassB, 5'd0, 5'd15, 5'd0, 1'b0, 1'b1);
		// idle cycle shows the last flag update
		regOp(aluPkg::opPassB, 5'd0, 5'd0, 5'd0, 1'b0, 1'b0);

		@(posedge clk);
		$display("checks %0d, mismatches %0d, assertion failures %0d",
			checkCount, errorCount, DUT.u_checker.failTotal);
		if (errorCount == 0 && DUT.u_checker.failTotal == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end
endmodule
